// ==== hw/recovery_pkg.sv ====
// Recovery handler package with constants, status codes and bus structs
`default_nettype none

package recovery_pkg;

  // Device status value that switches the target into recovery
  localparam logic [7:0] RecoveryMode = 8'h03;

  // Supported recovery commands are CmdBase .. CmdBase+NumCmds-1
  localparam logic [7:0]  CmdBase = 8'h22;
  localparam int unsigned NumCmds = 4;
  localparam int unsigned CmdIdxW = $clog2(NumCmds);

  // Largest payload held per command
  localparam int unsigned MaxLen = 4;

  // CRC-8 polynomial for the PEC
  localparam logic [7:0] PecPoly = 8'h07;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_strobe_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
    logic       last;
  } tx_byte_t;

  typedef enum logic [1:0] {
    RX_OK,
    RX_BAD_LEN,
    RX_BAD_PEC
  } rx_err_e;

  typedef enum logic [1:0] {
    ST_OK,
    ST_BAD_LEN,
    ST_BAD_PEC,
    ST_BAD_CMD
  } status_e;

  typedef struct packed {
    logic    valid;
    status_e status;
  } status_t;

  typedef struct packed {
    logic                   valid;
    logic [7:0]             cmd;
    logic [15:0]            len;
    logic [MaxLen-1:0][7:0] data;
    rx_err_e                err;
  } packet_t;

  typedef struct packed {
    logic [15:0]            len;
    logic [MaxLen-1:0][7:0] data;
  } resp_t;

endpackage

`default_nettype wire

// ==== hw/recovery_pec.sv ====
// Packet error code calculator, CRC-8 folding one byte per cycle
`timescale 1ns/1ps
`default_nettype none

module recovery_pec (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       clear_i,
  input  logic       valid_i,
  input  logic [7:0] data_i,
  output logic [7:0] crc_o
);
  import recovery_pkg::*;

  logic [7:0] crc_q;
  logic [7:0] crc_d;

  // MSB first, eight shift steps per byte
  always_comb begin
    crc_d = crc_q ^ data_i;
    for (int i = 0; i < 8; i++) begin
      crc_d = crc_d[7] ? ((crc_d << 1) ^ PecPoly) : (crc_d << 1);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      crc_q <= '0;
    end else if (clear_i) begin
      crc_q <= '0;
    end else if (valid_i) begin
      crc_q <= crc_d;
    end
  end

  assign crc_o = crc_q;

  a_clear_vs_valid : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(clear_i && valid_i))
    else $error("PEC cleared while a byte is folded in");

endmodule

`default_nettype wire

// ==== hw/recovery_receiver.sv ====
// Recovery receiver, forwards normal bytes and frames recovery packets
`timescale 1ns/1ps
`default_nettype none

module recovery_receiver (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       rec_en_i,
  input  recovery_pkg::byte_strobe_t rx_i,
  input  logic                       bus_stop_i,
  output recovery_pkg::byte_strobe_t tti_rx_o,
  output recovery_pkg::packet_t      packet_o
);
  import recovery_pkg::*;

  logic                   rec_byte;
  logic                   rec_stop;
  logic [16:0]            cnt_q;
  logic [7:0]             cmd_q;
  logic [15:0]            len_q;
  logic [MaxLen-1:0][7:0] data_q;
  logic [7:0]             last_q;
  logic [7:0]             crc_prev_q;
  logic [7:0]             crc;
  logic                   pkt_valid_q;
  rx_err_e                err_d;
  rx_err_e                err_q;

  // Normal mode bypass
  assign tti_rx_o.valid = rx_i.valid & ~rec_en_i;
  assign tti_rx_o.data  = rx_i.data;

  assign rec_byte = rx_i.valid & rec_en_i;
  assign rec_stop = bus_stop_i & rec_en_i & (cnt_q != '0);

  // Cleared at stop and held at zero outside recovery
  recovery_pec u_rx_pec (
    .clk_i,
    .arst_n_i,
    .clear_i (bus_stop_i | ~rec_en_i),
    .valid_i (rec_byte),
    .data_i  (rx_i.data),
    .crc_o   (crc)
  );

  // Length field first, then byte count, then PEC
  always_comb begin
    if (len_q > 16'(MaxLen) || cnt_q != {1'b0, len_q} + 17'd4) begin
      err_d = RX_BAD_LEN;
    end else if (crc_prev_q != last_q) begin
      err_d = RX_BAD_PEC;
    end else begin
      err_d = RX_OK;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q       <= '0;
      cmd_q       <= '0;
      len_q       <= '0;
      pkt_valid_q <= 1'b0;
      err_q       <= RX_OK;
    end else begin
      pkt_valid_q <= rec_stop;
      if (rec_stop) begin
        err_q <= err_d;
      end
      // Partial packets are dropped when recovery goes away
      if (!rec_en_i || bus_stop_i) begin
        cnt_q <= '0;
      end else if (rec_byte) begin
        if (cnt_q != '1) begin
          cnt_q <= cnt_q + 17'd1;
        end
        case (cnt_q)
          17'd0:   cmd_q       <= rx_i.data;
          17'd1:   len_q[7:0]  <= rx_i.data;
          17'd2:   len_q[15:8] <= rx_i.data;
          default: ;
        endcase
      end
    end
  end

  // Payload capture and the PEC one byte back
  always_ff @(posedge clk_i) begin
    if (rec_byte) begin
      last_q     <= rx_i.data;
      crc_prev_q <= crc;
      for (int i = 0; i < MaxLen; i++) begin
        if (cnt_q == 17'(i + 3)) begin
          data_q[i] <= rx_i.data;
        end
      end
    end
  end

  assign packet_o.valid = pkt_valid_q;
  assign packet_o.cmd   = cmd_q;
  assign packet_o.len   = len_q;
  assign packet_o.data  = data_q;
  assign packet_o.err   = err_q;

  a_no_byte_at_stop : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(rx_i.valid && bus_stop_i))
    else $error("Byte strobe coincides with bus stop");

endmodule

`default_nettype wire

// ==== hw/recovery_executor.sv ====
// Recovery executor, holds the register store and reports packet status
`timescale 1ns/1ps
`default_nettype none

module recovery_executor (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  recovery_pkg::packet_t packet_i,
  output recovery_pkg::resp_t   resp_o,
  output recovery_pkg::status_t status_o
);
  import recovery_pkg::*;

  logic [7:0]                          cmd_off;
  logic [CmdIdxW-1:0]                  idx;
  logic                                cmd_ok;
  status_e                             status_d;
  logic                                pkt_ok;
  logic                                wr_en;
  logic                                sel_en;
  logic [NumCmds-1:0][15:0]            len_q;
  logic [NumCmds-1:0][MaxLen-1:0][7:0] data_q;
  logic                                sel_valid_q;
  logic [CmdIdxW-1:0]                  sel_q;
  status_t                             status_q;

  // Offset wraps for codes below CmdBase so one compare covers both ends
  assign cmd_off = packet_i.cmd - CmdBase;
  assign idx     = cmd_off[CmdIdxW-1:0];
  assign cmd_ok  = cmd_off < NumCmds;

  always_comb begin
    case (packet_i.err)
      RX_BAD_LEN: status_d = ST_BAD_LEN;
      RX_BAD_PEC: status_d = ST_BAD_PEC;
      default:    status_d = cmd_ok ? ST_OK : ST_BAD_CMD;
    endcase
  end

  assign pkt_ok = packet_i.valid && (status_d == ST_OK);
  assign wr_en  = pkt_ok && (packet_i.len != '0);
  assign sel_en = pkt_ok && (packet_i.len == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      len_q       <= '0;
      sel_valid_q <= 1'b0;
      sel_q       <= '0;
      status_q    <= '0;
    end else begin
      status_q.valid  <= packet_i.valid;
      status_q.status <= status_d;
      if (wr_en) begin
        len_q[idx] <= packet_i.len;
      end
      // Zero length write picks the entry for the next read
      if (sel_en) begin
        sel_valid_q <= 1'b1;
        sel_q       <= idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      data_q[idx] <= packet_i.data;
    end
  end

  // Nothing selected reads back as an empty response
  always_comb begin
    resp_o = '0;
    if (sel_valid_q) begin
      resp_o.len  = len_q[sel_q];
      resp_o.data = data_q[sel_q];
    end
  end

  assign status_o = status_q;

  a_store_write : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_en |-> (packet_i.cmd >= CmdBase) && (packet_i.cmd < CmdBase + NumCmds)
              && (packet_i.len <= 16'(MaxLen)))
    else $error("Store written from an invalid packet");

endmodule

`default_nettype wire

// ==== hw/recovery_transmitter.sv ====
// Recovery transmitter, streams length, data and PEC for a read request
`timescale 1ns/1ps
`default_nettype none

module recovery_transmitter (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   tx_req_i,
  input  recovery_pkg::resp_t    resp_i,
  output recovery_pkg::tx_byte_t tx_o
);
  import recovery_pkg::*;

  logic        busy_q;
  logic [16:0] idx_q;
  resp_t       snap_q;
  logic        start;
  logic        last;
  logic [7:0]  crc;
  logic [7:0]  byte_d;

  // Requests during a response are dropped
  assign start = tx_req_i & ~busy_q;
  assign last  = busy_q && (idx_q == {1'b0, snap_q.len} + 17'd2);

  // Byte order is length low, length high, data, PEC
  always_comb begin
    byte_d = crc;
    if (idx_q == 17'd0) begin
      byte_d = snap_q.len[7:0];
    end else if (idx_q == 17'd1) begin
      byte_d = snap_q.len[15:8];
    end else begin
      for (int i = 0; i < MaxLen; i++) begin
        if (idx_q == 17'(i + 2) && 17'(i) < {1'b0, snap_q.len}) begin
          byte_d = snap_q.data[i];
        end
      end
    end
  end

  recovery_pec u_tx_pec (
    .clk_i,
    .arst_n_i,
    .clear_i (start),
    .valid_i (busy_q & ~last),
    .data_i  (byte_d),
    .crc_o   (crc)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (busy_q) begin
      busy_q <= ~last;
      idx_q  <= idx_q + 17'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      snap_q <= resp_i;
    end
  end

  assign tx_o.valid = busy_q;
  assign tx_o.data  = busy_q ? byte_d : 8'h00;
  assign tx_o.last  = last;

  a_resp_len : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    start |-> resp_i.len <= 16'(MaxLen))
    else $error("Response length exceeds the store");

endmodule

`default_nettype wire

// ==== hw/recovery_handler.sv ====
// Recovery handler top, mode detection and the receive-execute-transmit chain
`timescale 1ns/1ps
`default_nettype none

module recovery_handler (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic [7:0]                 dev_status_i,
  input  recovery_pkg::byte_strobe_t rx_i,
  input  logic                       bus_stop_i,
  input  logic                       tx_req_i,
  output recovery_pkg::byte_strobe_t tti_rx_o,
  output recovery_pkg::tx_byte_t     tx_o,
  output recovery_pkg::status_t      status_o
);
  import recovery_pkg::*;

  logic    rec_en;
  packet_t packet;
  resp_t   resp;

  // Recovery is entered through the device status byte
  assign rec_en = (dev_status_i == RecoveryMode);

  recovery_receiver u_receiver (
    .clk_i,
    .arst_n_i,
    .rec_en_i   (rec_en),
    .rx_i       (rx_i),
    .bus_stop_i (bus_stop_i),
    .tti_rx_o   (tti_rx_o),
    .packet_o   (packet)
  );

  recovery_executor u_executor (
    .clk_i,
    .arst_n_i,
    .packet_i (packet),
    .resp_o   (resp),
    .status_o (status_o)
  );

  // Read requests go straight to the transmitter
  recovery_transmitter u_transmitter (
    .clk_i,
    .arst_n_i,
    .tx_req_i (tx_req_i),
    .resp_i   (resp),
    .tx_o     (tx_o)
  );

endmodule

`default_nettype wire

// ==== bench/recovery_handler_model.svh ====
// Recovery handler reference model with store mirror, PEC and typed compare tasks
`ifndef RECOVERY_HANDLER_MODEL_SVH
`define RECOVERY_HANDLER_MODEL_SVH

  logic [15:0] m_len [NumCmds];
  logic [7:0]  m_data [NumCmds][MaxLen];
  logic        m_sel_valid;
  int          m_sel;
  logic [7:0]  pay_buf [10];
  // Expected outputs per cycle, indexed by cycle modulo ring size
  status_t     exp_status [64];
  tx_byte_t    exp_tx [64];
  int          tx_end;
  int          tti_errs;
  int          tx_errs;
  int          status_errs;

  task automatic reset_mirror();
    for (int i = 0; i < NumCmds; i++) begin
      m_len[i] = 16'h0000;
    end
    for (int i = 0; i < 64; i++) begin
      exp_status[i] = '0;
      exp_tx[i]     = '0;
    end
    m_sel_valid = 1'b0;
    m_sel       = 0;
    tx_end      = -1;
    tti_errs    = 0;
    tx_errs     = 0;
    status_errs = 0;
  endtask

  // CRC-8, polynomial 0x07, MSB first
  function automatic logic [7:0] pec_next(input logic [7:0] crc, input logic [7:0] b);
    logic [7:0] c;
    c = crc ^ b;
    for (int i = 0; i < 8; i++) begin
      c = c[7] ? ({c[6:0], 1'b0} ^ 8'h07) : {c[6:0], 1'b0};
    end
    return c;
  endfunction

  function automatic logic [7:0] packet_pec(input logic [7:0] cmd, input logic [15:0] len,
                                            input int n_pay);
    logic [7:0] crc;
    crc = pec_next(8'h00, cmd);
    crc = pec_next(crc, len[7:0]);
    crc = pec_next(crc, len[15:8]);
    for (int i = 0; i < n_pay; i++) begin
      crc = pec_next(crc, pay_buf[i]);
    end
    return crc;
  endfunction

  // Verdict for a finished packet, store updated only when it is good
  task automatic apply_packet(input logic [7:0] cmd, input logic [15:0] len, input int n_pay,
                              input logic [7:0] sent_pec, output status_e st);
    int idx;
    idx = int'(cmd - CmdBase);
    if (len > 16'(MaxLen) || n_pay != int'(len)) begin
      st = ST_BAD_LEN;
    end else if (packet_pec(cmd, len, n_pay) != sent_pec) begin
      st = ST_BAD_PEC;
    end else if (cmd < CmdBase || cmd >= CmdBase + 8'(NumCmds)) begin
      st = ST_BAD_CMD;
    end else begin
      st = ST_OK;
      if (len == 16'h0000) begin
        m_sel_valid = 1'b1;
        m_sel       = idx;
      end else begin
        m_len[idx] = len;
        for (int i = 0; i < int'(len); i++) begin
          m_data[idx][i] = pay_buf[i];
        end
      end
    end
  endtask

  // Response bytes land from the cycle after the request
  task automatic schedule_response(input int start);
    logic [15:0] len;
    logic [7:0]  crc;
    logic [7:0]  b;
    int          n;
    len = m_sel_valid ? m_len[m_sel] : 16'h0000;
    crc = 8'h00;
    n   = int'(len) + 3;
    for (int i = 0; i < n; i++) begin
      if (i == 0) begin
        b = len[7:0];
      end else if (i == 1) begin
        b = len[15:8];
      end else if (i < n - 1) begin
        b = m_data[m_sel][i - 2];
      end else begin
        b = crc;
      end
      crc = pec_next(crc, b);
      exp_tx[(start + 1 + i) % 64].valid = 1'b1;
      exp_tx[(start + 1 + i) % 64].data  = b;
      exp_tx[(start + 1 + i) % 64].last  = (i == n - 1);
    end
    tx_end = start + n;
  endtask

  function automatic byte_strobe_t expect_tti(input byte_strobe_t rx_v, input logic [7:0] ds);
    byte_strobe_t e;
    e.valid = rx_v.valid && (ds != RecoveryMode);
    e.data  = rx_v.data;
    return e;
  endfunction

  task automatic check_tti(input byte_strobe_t act, input byte_strobe_t want);
    if (act.valid !== want.valid || (want.valid && act.data !== want.data)) begin
      tti_errs++;
      $display("ERROR tti_rx_o at cycle %0d: got %h expected %h", cyc, act, want);
    end
  endtask

  task automatic check_tx(input tx_byte_t act, input tx_byte_t want);
    if (act.valid !== want.valid || act.last !== want.last ||
        (want.valid && act.data !== want.data)) begin
      tx_errs++;
      $display("ERROR tx_o at cycle %0d: got %h expected %h", cyc, act, want);
    end
  endtask

  task automatic check_status(input status_t act, input status_t want);
    if (act.valid !== want.valid || (want.valid && act.status !== want.status)) begin
      status_errs++;
      $display("ERROR status_o at cycle %0d: got %h expected %h", cyc, act, want);
    end
  endtask

`endif

// ==== bench/recovery_handler_tb.sv ====
// Recovery handler testbench, random packets and reads checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module recovery_handler_tb;
  import recovery_pkg::*;

  localparam int ClkPeriod   = 10;
  localparam int ResetCycles = 16;
  localparam int NumIters    = 80;
  // Worst iteration is a select packet plus a read with a repeated request
  localparam int IterCycles  = 32;
  localparam int WatchdogNs  = (ResetCycles + NumIters * IterCycles + 100) * ClkPeriod;

  logic         clk_i;
  logic         arst_n_i;
  logic [7:0]   dev_status_i;
  byte_strobe_t rx_i;
  logic         bus_stop_i;
  logic         tx_req_i;
  byte_strobe_t tti_rx_o;
  tx_byte_t     tx_o;
  status_t      status_o;
  logic [31:0]  lfsr_q;
  logic [7:0]   mode;
  int           cyc;

  `include "recovery_handler_model.svh"

  recovery_handler recovery_handler_i (
    .clk_i,
    .arst_n_i,
    .dev_status_i,
    .rx_i,
    .bus_stop_i,
    .tx_req_i,
    .tti_rx_o,
    .tx_o,
    .status_o
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hD000_0001) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic byte_strobe_t strobe(input logic [7:0] b);
    return {1'b1, b};
  endfunction

  // Registered outputs are checked first, then the next inputs go out
  task automatic tick(input byte_strobe_t rx_v, input logic stop_v, input logic req_v);
    @(negedge clk_i);
    cyc++;
    check_status(status_o, exp_status[cyc % 64]);
    check_tx(tx_o, exp_tx[cyc % 64]);
    exp_status[cyc % 64] = '0;
    exp_tx[cyc % 64]     = '0;
    dev_status_i = mode;
    rx_i         = rx_v;
    bus_stop_i   = stop_v;
    tx_req_i     = req_v;
    if (req_v && cyc > tx_end) begin
      schedule_response(cyc);
    end
    #1;
    check_tti(tti_rx_o, expect_tti(rx_v, dev_status_i));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      tick('0, 1'b0, 1'b0);
    end
  endtask

  task automatic send_packet(input logic [7:0] cmd, input logic [15:0] len, input int n_pay,
                             input logic [7:0] flip);
    logic [7:0] pec;
    status_e    st;
    for (int i = 0; i < n_pay; i++) begin
      pay_buf[i] = 8'(take_bits(8));
    end
    pec = packet_pec(cmd, len, n_pay) ^ flip;
    tick(strobe(cmd), 1'b0, 1'b0);
    tick(strobe(len[7:0]), 1'b0, 1'b0);
    tick(strobe(len[15:8]), 1'b0, 1'b0);
    for (int i = 0; i < n_pay; i++) begin
      tick(strobe(pay_buf[i]), 1'b0, 1'b0);
    end
    tick(strobe(pec), 1'b0, 1'b0);
    tick('0, 1'b1, 1'b0);
    // Status two cycles after the stop
    apply_packet(cmd, len, n_pay, pec, st);
    exp_status[(cyc + 2) % 64].valid  = 1'b1;
    exp_status[(cyc + 2) % 64].status = st;
    idle(3);
  endtask

  task automatic read_resp(input logic again);
    tick('0, 1'b0, 1'b1);
    if (again) begin
      idle(int'(take_bits(2)));
      tick('0, 1'b0, 1'b1);
    end
    while (!(tx_o.valid && tx_o.last) || cyc < tx_end) begin
      idle(1);
    end
    idle(2);
  endtask

  initial begin
    #(WatchdogNs);
    $display("Timeout: the test sequence did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int          kind;
    int          n;
    logic [7:0]  cmd;
    logic [15:0] len;
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    dev_status_i = 8'h00;
    rx_i         = '0;
    bus_stop_i   = 1'b0;
    tx_req_i     = 1'b0;
    lfsr_q       = 32'h53d0_2fc0;
    mode         = RecoveryMode;
    cyc          = 0;
    reset_mirror();
    repeat (ResetCycles) @(negedge clk_i);
    arst_n_i = 1'b1;
    // Nothing selected yet, empty response
    read_resp(1'b0);
    for (int it = 0; it < NumIters; it++) begin
      kind = int'(take_bits(3));
      cmd  = CmdBase + 8'(take_bits(2));
      len  = 16'(take_bits(2)) + 16'd1;
      case (kind)
        0: begin
          // Partial packet dropped when recovery goes away
          tick(strobe(cmd), 1'b0, 1'b0);
          mode = 8'(take_bits(8));
          if (mode == RecoveryMode) begin
            mode = 8'h00;
          end
          repeat (int'(take_bits(3)) + 1) begin
            if (take_bits(2) == 0) begin
              tick('0, 1'b1, 1'b0);
            end else begin
              tick(strobe(8'(take_bits(8))), 1'b0, 1'b0);
            end
          end
          idle(2);
          mode = RecoveryMode;
        end
        1, 2: send_packet(cmd, len, int'(len), 8'h00);
        3: begin
          send_packet(cmd, 16'h0000, 0, 8'h00);
          read_resp(1'(take_bits(1)));
        end
        4: send_packet(cmd, len, int'(len), 8'h01 << take_bits(3));
        5: begin
          if (take_bits(1) != 0) begin
            n = 5 + int'(take_bits(2));
            send_packet(cmd, 16'(n), n, 8'h00);
          end else begin
            n = (take_bits(1) != 0) ? int'(len) + 1 : int'(len) - 1;
            send_packet(cmd, len, n, 8'h00);
          end
        end
        6: begin
          cmd = 8'(take_bits(8));
          if (cmd >= CmdBase && cmd < CmdBase + 8'(NumCmds)) begin
            cmd = cmd + 8'h04;
          end
          send_packet(cmd, len, int'(len), 8'h00);
        end
        default: begin
          // Stop with no bytes is ignored
          tick('0, 1'b1, 1'b0);
          read_resp(1'b1);
        end
      endcase
    end
    idle(4);
    $display("Errors: tti_rx_o %0d, tx_o %0d, status_o %0d", tti_errs, tx_errs, status_errs);
    if (tti_errs + tx_errs + status_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== recovery_handler.f ====
+incdir+bench
hw/recovery_pkg.sv
hw/recovery_pec.sv
hw/recovery_receiver.sv
hw/recovery_executor.sv
hw/recovery_transmitter.sv
hw/recovery_handler.sv
bench/recovery_handler_tb.sv

// ==== Bender.yml ====
package:
  name: recovery_handler

sources:
  - files:
      - hw/recovery_pkg.sv
      - hw/recovery_pec.sv
      - hw/recovery_receiver.sv
      - hw/recovery_executor.sv
      - hw/recovery_transmitter.sv
      - hw/recovery_handler.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/recovery_handler_tb.sv
